// File: common/cache_geometry_pkg.sv
// Cache geometry for the 4-way L1 read cache: address split, counts and lookup types
package cache_geometry_pkg;

	// Address split  Tag:22 | Index:4 | Offset:6
	localparam int ADDR_W = 32;
	localparam int TAG_W = 22;
	localparam int INDEX_W = 4;
	localparam int OFFSET_W = 6; // 64 byte line
	localparam int WORD_SEL_W = 3; // Offset bits 5..3 pick the doubleword

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;

	// Age decay period in read cycles
	localparam int LRU_TIMER_W = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [1:0] way_t; // Way number 0..3
	typedef logic [WORD_SEL_W-1:0] word_sel_t;

	// 0 invalid, 1..3 age with 3 most recent
	typedef logic [1:0] status_t;

endpackage

// File: common/cache_payload_pkg.sv
// Cache payload definitions: line data, MMU flag lines and way status values
package cache_payload_pkg;

	// Data side
	localparam int LINE_W = 512;
	localparam int WORD_W = 64;

	// Flag side, one 32 bit slot per doubleword
	localparam int FLAG_LINE_W = 256;
	localparam int FLAG_SLOT_W = 32;
	localparam int MMU_FLAGS_W = 28; // Slot bits 29..16 and 13..0

	typedef logic [LINE_W-1:0] line_data_t;
	typedef logic [FLAG_LINE_W-1:0] line_flags_t;
	typedef logic [WORD_W-1:0] rd_word_t;
	typedef logic [MMU_FLAGS_W-1:0] mmu_flags_t;

	// Way status values
	localparam cache_geometry_pkg::status_t STATUS_INVALID = 2'd0;
	localparam cache_geometry_pkg::status_t STATUS_FLOOR = 2'd1; // Decay stops here
	localparam cache_geometry_pkg::status_t STATUS_MRU = 2'd3;

endpackage

// File: hw/line_ram.sv
// Line RAM: one way's 16-entry line store with whole-line write and held read address
`timescale 1ns/10ps

module line_ram #(
	parameter type payload_t = cache_payload_pkg::line_data_t
) (
	input logic iCLOCK,
	input logic wr_en,
	input cache_geometry_pkg::index_t wr_index,
	input payload_t wr_line,
	input cache_geometry_pkg::index_t rd_index,
	input logic rd_hold,
	output payload_t rd_line
);
	import cache_geometry_pkg::*;

	payload_t mem [NUM_SETS];
	index_t rd_index_q; // Registered read address

	// Whole line write, no byte enables
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_index] <= wr_line;
		end
	end

	// Stall keeps the addressed line on the output
	always_ff @(posedge iCLOCK) begin
		if (!rd_hold) begin
			rd_index_q <= rd_index;
		end
	end

	assign rd_line = mem[rd_index_q]; // Shows writes of earlier edges

	// Unknown index would corrupt an arbitrary set
	a_wr_index_known: assert property (@(posedge iCLOCK)
		wr_en |-> !$isunknown(wr_index));

endmodule

// File: hw/tag_store/tag_store.sv
// Tag store: per-set tags and ages, hit lookup, victim choice and the age timer
`timescale 1ns/10ps

module tag_store (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	input logic iRD_REQ,
	input cache_geometry_pkg::addr_t iRD_ADDR,
	input logic iRD_BUSY,
	input logic iWR_REQ,
	input cache_geometry_pkg::addr_t iWR_ADDR,
	output logic rd_hit,
	output cache_geometry_pkg::way_t rd_way,
	output logic [cache_geometry_pkg::NUM_WAYS-1:0] wr_en_way
);
	import cache_geometry_pkg::*;
	import cache_payload_pkg::*;

	tag_t tag_q [NUM_WAYS][NUM_SETS];
	status_t status_q [NUM_WAYS][NUM_SETS]; // Valid and age per entry
	logic [LRU_TIMER_W-1:0] timer_q;
	logic age_tick; // Period end

	index_t rd_index;
	index_t wr_index;
	tag_t rd_tag;
	tag_t wr_tag;
	logic [NUM_WAYS-1:0] rd_match;
	logic [NUM_WAYS-1:0] wr_match;
	way_t wr_way;
	logic rd_touch;

	assign rd_index = iRD_ADDR[OFFSET_W +: INDEX_W];
	assign rd_tag = iRD_ADDR[ADDR_W-1 -: TAG_W];
	assign wr_index = iWR_ADDR[OFFSET_W +: INDEX_W];
	assign wr_tag = iWR_ADDR[ADDR_W-1 -: TAG_W];

	// Tag compare, only valid entries match
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			rd_match[w] = (status_q[w][rd_index] != STATUS_INVALID)
				&& (tag_q[w][rd_index] == rd_tag);
			wr_match[w] = (status_q[w][wr_index] != STATUS_INVALID)
				&& (tag_q[w][wr_index] == wr_tag);
		end
	end

	// First matching way wins
	always_comb begin
		rd_hit = |rd_match;
		rd_way = '0;
		for (int w = NUM_WAYS-1; w >= 0; w--) begin
			if (rd_match[w]) begin
				rd_way = way_t'(w);
			end
		end
	end

	// Write way: matching line, else lowest status, else the last way
	always_comb begin
		wr_way = way_t'(NUM_WAYS-1); // All ways most recent
		if (|wr_match) begin
			for (int w = NUM_WAYS-1; w >= 0; w--) begin
				if (wr_match[w]) begin
					wr_way = way_t'(w);
				end
			end
		end
		else begin
			// Later passes override, so status 0 in the lowest way ends up chosen
			for (int st = int'(STATUS_MRU) - 1; st >= 0; st--) begin
				for (int w = NUM_WAYS-1; w >= 0; w--) begin
					if (status_q[w][wr_index] == status_t'(st)) begin
						wr_way = way_t'(w);
					end
				end
			end
		end
	end

	// Same enable drives the data and flag RAM of a way
	always_comb begin
		wr_en_way = '0;
		wr_en_way[wr_way] = iWR_REQ;
	end

	assign rd_touch = iRD_REQ && rd_hit;

	// Free-running age timer, frozen by the read stall
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			timer_q <= '0;
		end
		else if (iREMOVE) begin
			timer_q <= '0; // Flush restarts the period
		end
		else if (!iRD_BUSY) begin
			timer_q <= timer_q + 1'b1;
		end
	end

	assign age_tick = &timer_q;

	// Status update  flush > write > read hit/ageing
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					status_q[w][s] <= STATUS_INVALID;
				end
			end
		end
		else if (iREMOVE) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					status_q[w][s] <= STATUS_INVALID;
				end
			end
		end
		else if (iWR_REQ) begin
			status_q[wr_way][wr_index] <= STATUS_MRU; // No ageing on a write edge
		end
		else if (!iRD_BUSY) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					if (rd_touch && way_t'(w) == rd_way && index_t'(s) == rd_index) begin
						status_q[w][s] <= STATUS_MRU;
					end
					else if (age_tick && status_q[w][s] > STATUS_FLOOR) begin
						status_q[w][s] <= status_q[w][s] - 2'd1; // 3->2, 2->1
					end
				end
			end
		end
	end

	// Tag array
	always_ff @(posedge iCLOCK) begin
		if (iWR_REQ) begin
			tag_q[wr_way][wr_index] <= wr_tag;
		end
	end

	// A write lands in exactly one way of both RAM sets
	a_wr_onehot: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iWR_REQ |-> $onehot(wr_en_way));

	// Response stage registers rd_way on a hit, it must be clean
	a_rd_way_known: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> !$isunknown(rd_way));

endmodule

// File: hw/read_response.sv
// Read response stage: registers the lookup, picks way and doubleword, blanks under stall
`timescale 1ns/10ps

module read_response (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	input logic iRD_REQ,
	input logic iRD_BUSY,
	input logic rd_hit,
	input cache_geometry_pkg::way_t rd_way,
	input cache_geometry_pkg::word_sel_t rd_word,
	input cache_payload_pkg::line_data_t rd_data_way0,
	input cache_payload_pkg::line_data_t rd_data_way1,
	input cache_payload_pkg::line_data_t rd_data_way2,
	input cache_payload_pkg::line_data_t rd_data_way3,
	input cache_payload_pkg::line_flags_t rd_flags_way0,
	input cache_payload_pkg::line_flags_t rd_flags_way1,
	input cache_payload_pkg::line_flags_t rd_flags_way2,
	input cache_payload_pkg::line_flags_t rd_flags_way3,
	output logic oRD_VALID,
	output logic oRD_HIT,
	output cache_payload_pkg::rd_word_t oRD_DATA,
	output cache_payload_pkg::mmu_flags_t oRD_MMU_FLAGS
);
	import cache_geometry_pkg::*;
	import cache_payload_pkg::*;

	logic valid_q;
	logic hit_q;
	way_t way_q;
	word_sel_t word_q;
	line_data_t sel_line;
	line_flags_t sel_flags;
	logic [FLAG_SLOT_W-1:0] sel_slot;

	// Control state, held while the consumer stalls
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q <= 1'b0;
		end
		else if (iREMOVE) begin
			valid_q <= 1'b0; // Drop the pending result
			hit_q <= 1'b0;
		end
		else if (!iRD_BUSY) begin
			valid_q <= iRD_REQ;
			hit_q <= iRD_REQ && rd_hit; // Only a requested lookup can hit
		end
	end

	// Select fields only matter behind hit_q
	always_ff @(posedge iCLOCK) begin
		if (!iRD_BUSY) begin
			way_q <= rd_way;
			word_q <= rd_word;
		end
	end

	// Way mux
	always_comb begin
		case (way_q)
			2'd0: begin
				sel_line = rd_data_way0;
				sel_flags = rd_flags_way0;
			end
			2'd1: begin
				sel_line = rd_data_way1;
				sel_flags = rd_flags_way1;
			end
			2'd2: begin
				sel_line = rd_data_way2;
				sel_flags = rd_flags_way2;
			end
			default: begin
				sel_line = rd_data_way3;
				sel_flags = rd_flags_way3;
			end
		endcase
	end

	assign sel_slot = sel_flags[word_q*FLAG_SLOT_W +: FLAG_SLOT_W]; // One slot per doubleword

	assign oRD_VALID = valid_q && !iRD_BUSY;
	assign oRD_HIT = hit_q && !iRD_BUSY;
	assign oRD_DATA = oRD_HIT ? sel_line[word_q*WORD_W +: WORD_W] : '0;
	assign oRD_MMU_FLAGS = oRD_HIT ? {sel_slot[29:16], sel_slot[13:0]} : '0; // Bits 15:14 unused

	// A hit is never reported without a valid
	a_hit_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT |-> oRD_VALID);

endmodule

// File: hw/l1_cache.sv
// L1 read cache top: tag store, per-way data and flag RAMs and the response stage
`timescale 1ns/10ps

module l1_cache (
	input logic iCLOCK,
	input logic inRESET,
	input logic iREMOVE,
	input logic iRD_REQ,
	input cache_geometry_pkg::addr_t iRD_ADDR,
	input logic iRD_BUSY,
	output logic oRD_BUSY,
	output logic oRD_VALID,
	output logic oRD_HIT,
	output cache_payload_pkg::rd_word_t oRD_DATA,
	output cache_payload_pkg::mmu_flags_t oRD_MMU_FLAGS,
	input logic iWR_REQ,
	input cache_geometry_pkg::addr_t iWR_ADDR,
	input cache_payload_pkg::line_data_t iWR_DATA,
	input cache_payload_pkg::line_flags_t iWR_MMU_FLAGS
);
	import cache_geometry_pkg::*;
	import cache_payload_pkg::*;

	logic rd_hit;
	way_t rd_way;
	logic [NUM_WAYS-1:0] wr_en_way;
	logic rd_hold;
	index_t rd_index;
	index_t wr_index;
	word_sel_t rd_word;
	line_data_t data_way [NUM_WAYS];
	line_flags_t flags_way [NUM_WAYS];

	assign rd_hold = iRD_BUSY; // Stall freezes the read path
	assign rd_index = iRD_ADDR[OFFSET_W +: INDEX_W];
	assign wr_index = iWR_ADDR[OFFSET_W +: INDEX_W];
	assign rd_word = iRD_ADDR[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];

	// Advisory only, same-cycle read of a line being written
	assign oRD_BUSY = iRD_BUSY || (iRD_REQ && iWR_REQ && iRD_ADDR == iWR_ADDR);

	tag_store tag_store_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.iRD_REQ(iRD_REQ),
		.iRD_ADDR(iRD_ADDR),
		.iRD_BUSY(iRD_BUSY),
		.iWR_REQ(iWR_REQ),
		.iWR_ADDR(iWR_ADDR),
		.rd_hit(rd_hit),
		.rd_way(rd_way),
		.wr_en_way(wr_en_way)
	);

	// Data and flag RAM per way
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		line_ram #(.payload_t(line_data_t)) data_ram_i (
			.iCLOCK(iCLOCK),
			.wr_en(wr_en_way[w]),
			.wr_index(wr_index),
			.wr_line(iWR_DATA),
			.rd_index(rd_index),
			.rd_hold(rd_hold),
			.rd_line(data_way[w])
		);

		line_ram #(.payload_t(line_flags_t)) flag_ram_i (
			.iCLOCK(iCLOCK),
			.wr_en(wr_en_way[w]),
			.wr_index(wr_index),
			.wr_line(iWR_MMU_FLAGS),
			.rd_index(rd_index),
			.rd_hold(rd_hold),
			.rd_line(flags_way[w])
		);
	end

	read_response read_response_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.iRD_REQ(iRD_REQ),
		.iRD_BUSY(iRD_BUSY),
		.rd_hit(rd_hit),
		.rd_way(rd_way),
		.rd_word(rd_word),
		.rd_data_way0(data_way[0]),
		.rd_data_way1(data_way[1]),
		.rd_data_way2(data_way[2]),
		.rd_data_way3(data_way[3]),
		.rd_flags_way0(flags_way[0]),
		.rd_flags_way1(flags_way[1]),
		.rd_flags_way2(flags_way[2]),
		.rd_flags_way3(flags_way[3]),
		.oRD_VALID(oRD_VALID),
		.oRD_HIT(oRD_HIT),
		.oRD_DATA(oRD_DATA),
		.oRD_MMU_FLAGS(oRD_MMU_FLAGS)
	);

endmodule

// File: dv/l1_cache_tb.sv
// Testbench for the L1 read cache, table-driven stimulus checked against a tag and age model
`timescale 1ns/10ps

module l1_cache_tb;
	import cache_geometry_pkg::*;
	import cache_payload_pkg::*;

	typedef enum int {OP_READ, OP_WRITE, OP_IDLE, OP_FLUSH, OP_STALL, OP_RW} op_e;

	typedef struct {
		op_e op;
		addr_t addr; // Read address, write address for OP_WRITE
		addr_t addr2; // Write side of OP_RW
		int cycles;
		logic exp_hit; // Hit expected for this read
		logic exp_busy; // oRD_BUSY expected during the row
		int line; // Payload index of a write
	} row_t;

	logic iCLOCK;
	logic inRESET;
	logic iREMOVE;
	logic iRD_REQ;
	addr_t iRD_ADDR;
	logic iRD_BUSY;
	logic oRD_BUSY;
	logic oRD_VALID;
	logic oRD_HIT;
	rd_word_t oRD_DATA;
	mmu_flags_t oRD_MMU_FLAGS;
	logic iWR_REQ;
	addr_t iWR_ADDR;
	line_data_t iWR_DATA;
	line_flags_t iWR_MMU_FLAGS;

	row_t rows[$];
	line_data_t data_lines [16];
	line_flags_t flag_lines [16];
	int next_line = 0;
	int total_cycles = 0;
	int cycle_count = 0;
	int cycle_limit = 1000; // Replaced once the table is built
	int error_count = 0;

	// Reference model of the tag store
	tag_t ref_tag [NUM_SETS][NUM_WAYS];
	int ref_stat [NUM_SETS][NUM_WAYS]; // 0 invalid, 3 most recent
	int ref_line [NUM_SETS][NUM_WAYS]; // Which payload sits in each way
	logic [LRU_TIMER_W-1:0] ref_timer;

	// Model of the response registers
	logic resp_valid;
	logic resp_hit;
	logic resp_tab_hit;
	int resp_set;
	int resp_way;
	int resp_word;

	int drv_line; // Payload on the write port
	logic drv_tab_hit;
	logic tab_busy;

	l1_cache dut_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.iRD_REQ(iRD_REQ),
		.iRD_ADDR(iRD_ADDR),
		.iRD_BUSY(iRD_BUSY),
		.oRD_BUSY(oRD_BUSY),
		.oRD_VALID(oRD_VALID),
		.oRD_HIT(oRD_HIT),
		.oRD_DATA(oRD_DATA),
		.oRD_MMU_FLAGS(oRD_MMU_FLAGS),
		.iWR_REQ(iWR_REQ),
		.iWR_ADDR(iWR_ADDR),
		.iWR_DATA(iWR_DATA),
		.iWR_MMU_FLAGS(iWR_MMU_FLAGS)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK; // 20 ns period
	end

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge iCLOCK);
		end
		$display("Timeout: the run passed %0d cycles without finishing the table", cycle_limit);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic addr_t make_addr(tag_t tag, int idx, int word);
		return {tag, index_t'(idx), word_sel_t'(word), 3'b000};
	endfunction

	// Tags 0x100.. all in set 5
	function automatic addr_t set5_addr(int i);
		return make_addr(tag_t'(22'h100 + i), 5, i);
	endfunction

	// Doubleword k is bits 64k+63..64k
	function automatic rd_word_t word_of(line_data_t line, int k);
		line_data_t shifted;
		shifted = line >> (k * WORD_W);
		return shifted[WORD_W-1:0];
	endfunction

	// Slot k, bits 29..16 then 13..0
	function automatic mmu_flags_t flags_of(line_flags_t line, int k);
		line_flags_t shifted;
		logic [31:0] slot;
		shifted = line >> (k * FLAG_SLOT_W);
		slot = shifted[31:0];
		return {slot[29:16], slot[13:0]};
	endfunction

	function automatic int find_way(addr_t addr);
		int idx;
		idx = int'(addr[OFFSET_W +: INDEX_W]);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_stat[idx][w] != 0 && ref_tag[idx][w] == addr[ADDR_W-1 -: TAG_W]) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Lowest status first, lowest way first
	function automatic int pick_victim(int idx);
		for (int st = 0; st < 3; st++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (ref_stat[idx][w] == st) begin
					return w;
				end
			end
		end
		return NUM_WAYS - 1; // Every way most recent
	endfunction

	// One clock edge of the reference model
	task automatic model_edge();
		int rd_set;
		int wr_set;
		int rd_way_ref;
		int wr_way_ref;
		logic tick;
		rd_set = int'(iRD_ADDR[OFFSET_W +: INDEX_W]);
		wr_set = int'(iWR_ADDR[OFFSET_W +: INDEX_W]);
		rd_way_ref = find_way(iRD_ADDR); // Lookup before this edge's write
		tick = (ref_timer == '1);
		if (iREMOVE) begin
			resp_valid = 1'b0;
			resp_hit = 1'b0;
		end
		else if (!iRD_BUSY) begin
			resp_valid = iRD_REQ;
			resp_hit = (rd_way_ref >= 0);
			resp_set = rd_set;
			resp_way = rd_way_ref;
			resp_word = int'(iRD_ADDR[OFFSET_W-1 -: WORD_SEL_W]);
			resp_tab_hit = drv_tab_hit;
		end
		if (iREMOVE) begin
			foreach (ref_stat[s, w]) begin
				ref_stat[s][w] = 0;
			end
		end
		else if (iWR_REQ) begin
			wr_way_ref = find_way(iWR_ADDR);
			if (wr_way_ref < 0) begin
				wr_way_ref = pick_victim(wr_set);
			end
			ref_tag[wr_set][wr_way_ref] = iWR_ADDR[ADDR_W-1 -: TAG_W];
			ref_stat[wr_set][wr_way_ref] = 3;
			ref_line[wr_set][wr_way_ref] = drv_line;
		end
		else if (!iRD_BUSY) begin
			foreach (ref_stat[s, w]) begin
				if (iRD_REQ && s == rd_set && w == rd_way_ref) begin
					ref_stat[s][w] = 3;
				end
				else if (tick && ref_stat[s][w] > 1) begin
					ref_stat[s][w]--; // Decay stops at 1
				end
			end
		end
		if (iREMOVE) begin
			ref_timer = '0;
		end
		else if (!iRD_BUSY) begin
			ref_timer++;
		end
	endtask

	// Outputs in mid cycle against the model
	task automatic check_outputs();
		logic exp_valid;
		logic exp_hit;
		rd_word_t exp_data;
		mmu_flags_t exp_flags;
		exp_valid = resp_valid && !iRD_BUSY; // Stall blanks the result
		exp_hit = exp_valid && resp_hit;
		exp_data = '0;
		exp_flags = '0;
		if (exp_hit) begin
			exp_data = word_of(data_lines[ref_line[resp_set][resp_way]], resp_word);
			exp_flags = flags_of(flag_lines[ref_line[resp_set][resp_way]], resp_word);
		end
		check("oRD_VALID", oRD_VALID, exp_valid);
		if (exp_valid) begin
			check("oRD_HIT (table)", oRD_HIT, resp_tab_hit);
		end
		check("oRD_HIT", oRD_HIT, exp_hit);
		check("oRD_DATA", oRD_DATA, exp_data);
		check("oRD_MMU_FLAGS", oRD_MMU_FLAGS, exp_flags);
		check("oRD_BUSY", oRD_BUSY, tab_busy);
	endtask

	task automatic run_cycle();
		#10;
		check_outputs();
		@(posedge iCLOCK);
		model_edge();
		#2; // Next drive point
	endtask

	task automatic drive_idle();
		iRD_REQ = 1'b0;
		iWR_REQ = 1'b0;
		iREMOVE = 1'b0;
		iRD_BUSY = 1'b0;
	endtask

	task automatic drive_write(addr_t addr, int line);
		iWR_REQ = 1'b1;
		iWR_ADDR = addr;
		iWR_DATA = data_lines[line];
		iWR_MMU_FLAGS = flag_lines[line];
		drv_line = line;
	endtask

	task automatic apply_row(row_t r);
		drive_idle();
		tab_busy = r.exp_busy;
		case (r.op)
			OP_READ: begin
				iRD_REQ = 1'b1;
				iRD_ADDR = r.addr;
				drv_tab_hit = r.exp_hit;
			end
			OP_WRITE: begin
				drive_write(r.addr, r.line);
			end
			OP_FLUSH: begin
				iREMOVE = 1'b1;
			end
			OP_STALL: begin
				iRD_BUSY = 1'b1;
			end
			OP_RW: begin
				iRD_REQ = 1'b1;
				iRD_ADDR = r.addr;
				drv_tab_hit = r.exp_hit;
				drive_write(r.addr2, r.line);
			end
			default: begin
			end
		endcase
		repeat (r.cycles) begin
			run_cycle();
		end
	endtask

	task automatic add_row(op_e op, addr_t addr, addr_t addr2, int cycles,
		logic exp_hit, logic exp_busy);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.addr2 = addr2;
		r.cycles = cycles;
		r.exp_hit = exp_hit;
		r.exp_busy = exp_busy;
		r.line = 0;
		if (op == OP_WRITE || op == OP_RW) begin
			r.line = next_line; // Fresh payload per write
			next_line++;
		end
		rows.push_back(r);
		total_cycles += cycles;
	endtask

	task automatic build_table();
		addr_t x_addr;
		addr_t x2_addr;
		x_addr = make_addr(22'h01234, 1, 0);
		x2_addr = make_addr(22'h00077, 1, 0); // Same set as x_addr
		add_row(OP_READ, make_addr(22'h3, 2, 0), '0, 1, 1'b0, 1'b0); // Empty cache
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		add_row(OP_WRITE, x_addr, '0, 1, 1'b0, 1'b0);
		for (int k = 0; k < 8; k++) begin
			add_row(OP_READ, make_addr(22'h01234, 1, k), '0, 1, 1'b1, 1'b0);
		end
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		// Fifth tag evicts way 3
		for (int i = 0; i < 5; i++) begin
			add_row(OP_WRITE, set5_addr(i), '0, 1, 1'b0, 1'b0);
		end
		add_row(OP_READ, set5_addr(3), '0, 1, 1'b0, 1'b0);
		for (int i = 0; i < 5; i++) begin
			if (i != 3) begin
				add_row(OP_READ, set5_addr(i), '0, 1, 1'b1, 1'b0);
			end
		end
		add_row(OP_IDLE, '0, '0, 131100, 1'b0, 1'b0); // Two age periods, all decay to 1
		add_row(OP_READ, set5_addr(2), '0, 1, 1'b1, 1'b0);
		add_row(OP_WRITE, set5_addr(5), '0, 1, 1'b0, 1'b0); // Lands in way 0
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		add_row(OP_READ, set5_addr(0), '0, 1, 1'b0, 1'b0);
		for (int i = 1; i < 6; i++) begin
			if (i != 3) begin
				add_row(OP_READ, set5_addr(i), '0, 1, 1'b1, 1'b0);
			end
		end
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		// Stalled hit, then flush
		add_row(OP_READ, set5_addr(1), '0, 1, 1'b1, 1'b0);
		add_row(OP_STALL, '0, '0, 3, 1'b0, 1'b1);
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		add_row(OP_FLUSH, '0, '0, 1, 1'b0, 1'b0);
		add_row(OP_READ, x_addr, '0, 1, 1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			add_row(OP_READ, set5_addr(i), '0, 1, 1'b0, 1'b0);
		end
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
		// Collision flag
		add_row(OP_RW, x_addr, x_addr, 1, 1'b0, 1'b1);
		add_row(OP_RW, x_addr, x2_addr, 1, 1'b1, 1'b0);
		add_row(OP_READ, x2_addr, '0, 1, 1'b1, 1'b0);
		add_row(OP_IDLE, '0, '0, 1, 1'b0, 1'b0);
	endtask

	initial begin
		void'($urandom(1593));
		inRESET = 1'b0;
		iREMOVE = 1'b0;
		iRD_REQ = 1'b0;
		iRD_ADDR = '0;
		iRD_BUSY = 1'b0;
		iWR_REQ = 1'b0;
		iWR_ADDR = '0;
		iWR_DATA = '0;
		iWR_MMU_FLAGS = '0;
		drv_line = 0;
		drv_tab_hit = 1'b0;
		tab_busy = 1'b0;
		resp_valid = 1'b0;
		resp_hit = 1'b0;
		resp_tab_hit = 1'b0;
		resp_set = 0;
		resp_way = 0;
		resp_word = 0;
		ref_timer = '0;
		foreach (ref_stat[s, w]) begin
			ref_stat[s][w] = 0;
			ref_tag[s][w] = '0;
			ref_line[s][w] = 0;
		end
		for (int i = 0; i < 16; i++) begin
			for (int j = 0; j < LINE_W / 32; j++) begin
				data_lines[i][j*32 +: 32] = $urandom;
			end
			for (int j = 0; j < FLAG_LINE_W / 32; j++) begin
				flag_lines[i][j*32 +: 32] = $urandom;
			end
		end
		build_table();
		cycle_limit = total_cycles + 5 + 100; // Reset plus margin
		repeat (5) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		if (error_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end
		else begin
			$display("Result: FAILED");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

endmodule

// File: l1_cache.f
common/cache_geometry_pkg.sv
common/cache_payload_pkg.sv
hw/line_ram.sv
hw/tag_store/tag_store.sv
hw/read_response.sv
hw/l1_cache.sv
dv/l1_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = l1_cache_tb
FILELIST  = l1_cache.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
